// File: build.f
+incdir+logic
logic/pkt_format_pkg.sv
logic/pkt_check_pkg.sv
logic/hdr_ecc_decoder.sv
logic/crc8_accum.sv
logic/byte_addr_counter.sv
logic/pkt_check_fsm.sv
logic/pkt_check_top.sv
tests/pkt_check_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= pkt_check_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/pkt_check_tb.sv
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module pkt_check_tb;

  import pkt_format_pkg::*;
  import pkt_check_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  // packet groups
  localparam int N_CLEAN  = 24;
  localparam int N_BADCRC = 3;
  localparam int N_SINGLE = 12;
  localparam int N_DOUBLE = 4;
  localparam int N_PKTS   = N_CLEAN + N_BADCRC + N_SINGLE + N_DOUBLE + 1;
  // launch edge, header, 15 payload words, crc word, compare, done, spare
  localparam int MAX_PKT_CYCLES  = 2 + 1 + 15 + 1 + 1 + 1 + 2;
  localparam int WAIT_LIMIT      = 40;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 30 + N_PKTS * MAX_PKT_CYCLES + 200;
  localparam logic [31:0] SEED   = 32'h9a136df1;

  logic                clk;
  logic                reset;
  logic                start;
  mem_addr_t           addr_hdr;
  logic [31:0]         mem_rdata;
  mem_addr_t           mem_addr;
  logic                busy;
  logic                done;
  chk_status_t         status;

  // packet memory, read combinationally at the DUT address
  logic [31:0]         mem [0:`PKT_MEM_DEPTH-1];
  logic [7:0]          pay_bytes [0:15];

  // expectations of the packet in flight
  string               test_name;
  chk_status_t         exp_status;
  int                  exp_lat;
  // tb view of the packet walk
  logic                outstanding;
  logic                fresh;
  int                  since_start;
  int                  accepted;
  int                  dones;
  int                  packets;
  int                  errors;

  assign mem_rdata = mem[mem_addr];

  pkt_check_top UUT (
    .clk         (clk),
    .reset       (reset),
    .start_i     (start),
    .addr_hdr_i  (addr_hdr),
    .mem_rdata_i (mem_rdata),
    .mem_addr_o  (mem_addr),
    .busy_o      (busy),
    .done_o      (done),
    .status_o    (status)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference models
  //////////////////////////////////////////////////////////////////////

  // returns {overall parity, code}
  function automatic logic [4:0] ecc_encode(input logic [7:0] d);
    logic [3:0] c;
    c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
    c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
    c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
    c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
    return {^d, c};
  endfunction

  // header word with random filler in the unused half
  function automatic logic [31:0] make_header(input logic [3:0] ptype, input logic [3:0] cnt);
    logic [4:0]  e;
    logic [31:0] r;
    e = ecc_encode({ptype, cnt});
    r = $urandom;
    return {r[15:0], 3'b101, e[4], ptype, cnt, e[3:0]};
  endfunction

  function automatic chk_status_t make_status(input logic crc_err, input logic corr,
                                              input logic uncorr, input logic [7:0] data);
    chk_status_t s;
    s.crc_err    = crc_err;
    s.ecc_corr   = corr;
    s.ecc_uncorr = uncorr;
    s.pkt_type   = data[7:4];
    s.byte_cnt   = data[3:0];
    return s;
  endfunction

  // bit-serial crc-8, msb first, zero seed
  task automatic crc_ref(input int n, output logic [7:0] crc);
    logic fb;
    crc = 8'h00;
    for (int i = 0; i < n; i++) begin
      for (int b = 7; b >= 0; b--) begin
        fb  = crc[7] ^ pay_bytes[i][b];
        crc = {crc[6:0], 1'b0};
        if (fb) begin
          crc = crc ^ `PKT_CRC_POLY;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // payload and crc words, then the header with flip applied to bits 12:0
  task automatic write_packet(input mem_addr_t base, input logic [3:0] ptype,
                              input logic [3:0] cnt, input logic [12:0] flip,
                              input logic [7:0] crc_xor);
    logic [31:0] r;
    logic [7:0]  crc;
    for (int i = 0; i < int'(cnt); i++) begin
      r = $urandom;
      pay_bytes[i] = r[7:0];
      mem[base + mem_addr_t'(i + 1)] = r;
    end
    crc_ref(int'(cnt), crc);
    r = $urandom;
    mem[base + mem_addr_t'(cnt) + mem_addr_t'(1)] = {r[31:8], crc ^ crc_xor};
    mem[base] = make_header(ptype, cnt) ^ {19'h0, flip};
  endtask

  // one start strobe, optional extra strobe pulse_at cycles into the walk
  task automatic send_packet(input string name, input mem_addr_t base, input int pulse_at);
    int k;
    @(posedge clk);
    test_name = name;
    addr_hdr <= base;
    start    <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    k = 0;
    do begin
      @(posedge clk);
      k++;
      if (pulse_at > 0 && k == pulse_at) begin
        start <= 1'b1;
      end
      if (pulse_at > 0 && k == pulse_at + 1) begin
        start <= 1'b0;
      end
    end while (!done && k < WAIT_LIMIT);
    start <= 1'b0;
    if (!done) begin
      errors++;
      $display("done_o never arrived for %s", name);
    end
    packets++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // packet tracking and checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
      fresh       <= 1'b1;
      since_start <= 0;
    end else begin
      since_start <= since_start + 1;
      if (start) begin
        fresh <= 1'b0;
      end
      if (start && !outstanding) begin
        outstanding <= 1'b1;
        since_start <= 0;
        accepted    <= accepted + 1;
      end else if (done) begin
        outstanding <= 1'b0;
      end
      if (done) begin
        dones <= dones + 1;
      end
    end
  end

  a_status: assert property (@(posedge clk) disable iff (reset) done |-> status == exp_status)
    else begin
      errors++;
      $display("CHECK FAILED %s status expected %h actual %h", test_name, exp_status, status);
    end

  // cycles from the start edge to the edge that raised done
  a_latency: assert property (@(posedge clk) disable iff (reset) done |-> since_start == exp_lat)
    else begin
      errors++;
      $display("CHECK FAILED %s latency expected %0d actual %0d",
               test_name, exp_lat, $sampled(since_start));
    end

  // header word first, then one word per cycle up to the crc word
  a_mem_addr: assert property (@(posedge clk) disable iff (reset)
                               (outstanding && since_start < exp_lat - 1)
                               |-> mem_addr == addr_hdr + mem_addr_t'(since_start))
    else begin
      errors++;
      $display("CHECK FAILED %s mem_addr expected %h actual %h", test_name,
               $sampled(addr_hdr + mem_addr_t'(since_start)), $sampled(mem_addr));
    end

  a_no_extra_done: assert property (@(posedge clk) disable iff (reset) done |-> outstanding)
    else begin
      errors++;
      $display("done_o pulsed with no packet running (%s)", test_name);
    end

  a_busy: assert property (@(posedge clk) disable iff (reset) busy == (outstanding && !done))
    else begin
      errors++;
      $display("CHECK FAILED %s busy_o expected %b actual %b",
               test_name, $sampled(outstanding && !done), $sampled(busy));
    end

  a_status_hold: assert property (@(posedge clk) disable iff (reset) !done |-> $stable(status))
    else begin
      errors++;
      $display("status_o changed without done_o (%s)", test_name);
    end

  // nothing moves between reset and the first start
  a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
                                  fresh |-> (!done && !busy && status == '0))
    else begin
      errors++;
      $display("CHECK FAILED after_reset outputs expected 0 actual done %b busy %b status %h",
               done, busy, status);
    end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    mem_addr_t  base;
    logic [3:0] ptype;
    logic [3:0] cnt;
    logic [12:0] flip;
    int         di;
    int         dj;
    void'($urandom(SEED));
    reset    = 1'b1;
    start    = 1'b0;
    addr_hdr = '0;
    accepted = 0;
    dones    = 0;
    packets  = 0;
    errors   = 0;
    test_name = "after_reset";
    exp_status = '0;
    exp_lat    = 0;
    // fill depends on every address bit
    for (int a = 0; a < `PKT_MEM_DEPTH; a++) begin
      mem[a] = 32'(a) * 32'h9e3779b1;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    repeat (6) @(posedge clk);
    base = mem_addr_t'(16);

    // clean packets, every length at least once
    for (int n = 0; n < N_CLEAN; n++) begin
      ptype = 4'($urandom);
      cnt   = (n < 16) ? 4'(n) : 4'($urandom);
      write_packet(base, ptype, cnt, 13'h0, 8'h00);
      exp_status = make_status(1'b0, 1'b0, 1'b0, {ptype, cnt});
      exp_lat    = int'(cnt) + 3;
      send_packet("clean", base, 0);
      base = base + mem_addr_t'(20);
    end

    // stored crc byte damaged
    for (int n = 0; n < N_BADCRC; n++) begin
      ptype = 4'($urandom);
      cnt   = 4'($urandom);
      write_packet(base, ptype, cnt, 13'h0, 8'h01 << n);
      exp_status = make_status(1'b1, 1'b0, 1'b0, {ptype, cnt});
      exp_lat    = int'(cnt) + 3;
      send_packet("bad_crc", base, 0);
      base = base + mem_addr_t'(20);
    end

    // one data bit, or one code bit together with the parity bit
    for (int n = 0; n < N_SINGLE; n++) begin
      ptype = 4'($urandom);
      cnt   = 4'($urandom);
      if (n < 8) begin
        flip = 13'(1) << (4 + n);
      end else begin
        flip = (13'(1) << (n - 8)) | 13'h1000;
      end
      write_packet(base, ptype, cnt, flip, 8'h00);
      exp_status = make_status(1'b0, 1'b1, 1'b0, {ptype, cnt});
      exp_lat    = int'(cnt) + 3;
      send_packet("single_flip", base, 0);
      base = base + mem_addr_t'(20);
    end

    // two data bits, header kept as received and no walk
    for (int n = 0; n < N_DOUBLE; n++) begin
      ptype = 4'($urandom);
      cnt   = 4'($urandom);
      di    = int'($urandom % 8);
      dj    = (di + 1 + int'($urandom % 7)) % 8;
      flip  = (13'(1) << (4 + di)) | (13'(1) << (4 + dj));
      write_packet(base, ptype, cnt, flip, 8'h00);
      exp_status = make_status(1'b0, 1'b0, 1'b1,
                               {ptype, cnt} ^ ((8'(1) << di) | (8'(1) << dj)));
      exp_lat    = 3;
      send_packet("double_flip", base, 0);
      base = base + mem_addr_t'(20);
    end

    // extra strobe mid-walk must be dropped
    ptype = 4'($urandom);
    cnt   = 4'd12;
    write_packet(base, ptype, cnt, 13'h0, 8'h00);
    exp_status = make_status(1'b0, 1'b0, 1'b0, {ptype, cnt});
    exp_lat    = int'(cnt) + 3;
    send_packet("start_while_busy", base, 3);
    repeat (8) @(posedge clk);

    assert (dones == accepted && accepted == N_PKTS)
      else begin
        errors++;
        $display("CHECK FAILED done_count expected %0d actual %0d", N_PKTS, dones);
      end

    $display("%0d packets, %0d done pulses, %0d errors", packets, dones, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: logic/pkt_check_top.sv
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module pkt_check_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start_i,
  input  pkt_format_pkg::mem_addr_t  addr_hdr_i,
  input  logic [`PKT_WORD_W-1:0]     mem_rdata_i,
  output pkt_format_pkg::mem_addr_t  mem_addr_o,
  output logic                       busy_o,
  output logic                       done_o,
  output pkt_check_pkg::chk_status_t status_o
);

  import pkt_format_pkg::*;
  import pkt_check_pkg::*;

  pkt_hdr_t               hdr_word;
  hdr_byte_t              ecc_data;
  ecc_class_e             ecc_class;
  mem_addr_t              cnt_addr;
  logic                   cnt_last;
  logic                   cnt_load;
  logic                   cnt_step;
  logic                   crc_clear;
  logic                   crc_step;
  logic                   hdr_sel;
  logic [`PKT_BYTE_W-1:0] crc_val;
  logic [`PKT_BYTE_W-1:0] rdata_byte;

  // read data seen as a header word or as a payload lane
  assign hdr_word   = pkt_hdr_t'(mem_rdata_i);
  assign rdata_byte = mem_rdata_i[`PKT_BYTE_W-1:0];

  // header address only during the header read
  assign mem_addr_o = hdr_sel ? addr_hdr_i : cnt_addr;

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  hdr_ecc_decoder u_ecc (
    .hdr_i   (hdr_word),
    .data_o  (ecc_data),
    .class_o (ecc_class)
  );

  // loads the corrected length straight from the decoder
  byte_addr_counter u_cnt (
    .clk     (clk),
    .reset   (reset),
    .load_i  (cnt_load),
    .step_i  (cnt_step),
    .base_i  (addr_hdr_i),
    .count_i (ecc_data.byte_cnt),
    .addr_o  (cnt_addr),
    .last_o  (cnt_last)
  );

  crc8_accum u_crc (
    .clk     (clk),
    .reset   (reset),
    .clear_i (crc_clear),
    .step_i  (crc_step),
    .byte_i  (rdata_byte),
    .crc_o   (crc_val)
  );

  pkt_check_fsm u_fsm (
    .clk          (clk),
    .reset        (reset),
    .start_i      (start_i),
    .addr_hdr_i   (addr_hdr_i),
    .ecc_data_i   (ecc_data),
    .ecc_class_i  (ecc_class),
    .last_i       (cnt_last),
    .crc_i        (crc_val),
    .rdata_byte_i (rdata_byte),
    .cnt_load_o   (cnt_load),
    .cnt_step_o   (cnt_step),
    .crc_clear_o  (crc_clear),
    .crc_step_o   (crc_step),
    .hdr_sel_o    (hdr_sel),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .status_o     (status_o)
  );

endmodule

// File: logic/pkt_check_fsm.sv
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module pkt_check_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start_i,
  input  pkt_format_pkg::mem_addr_t  addr_hdr_i,
  input  pkt_format_pkg::hdr_byte_t  ecc_data_i,
  input  pkt_check_pkg::ecc_class_e  ecc_class_i,
  input  logic                       last_i,
  input  logic [`PKT_BYTE_W-1:0]     crc_i,
  input  logic [`PKT_BYTE_W-1:0]     rdata_byte_i,
  output logic                       cnt_load_o,
  output logic                       cnt_step_o,
  output logic                       crc_clear_o,
  output logic                       crc_step_o,
  output logic                       hdr_sel_o,
  output logic                       busy_o,
  output logic                       done_o,
  output pkt_check_pkg::chk_status_t status_o
);

  import pkt_format_pkg::*;
  import pkt_check_pkg::*;

  chk_state_e             state_q;
  chk_state_e             state_d;
  ecc_class_e             class_q;
  hdr_byte_t              hdr_q;
  logic [`PKT_BYTE_W-1:0] crc_ref_q;
  logic                   done_q;
  chk_status_t            status_q;
  logic                   skip_walk;

  // uncorrectable header, byte count cannot be trusted
  assign skip_walk = (class_q == ECC_UNCORR);

  //////////////////////////////////////////////////////////////////////
  // next state and strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    cnt_load_o  = 1'b0;
    cnt_step_o  = 1'b0;
    crc_clear_o = 1'b0;
    crc_step_o  = 1'b0;
    hdr_sel_o   = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = HEADER_READ;
        end
      end
      HEADER_READ: begin
        // header word on the bus, decoder output is live this cycle
        hdr_sel_o   = 1'b1;
        cnt_load_o  = 1'b1;
        crc_clear_o = 1'b1;
        state_d     = CRC_CALC;
      end
      CRC_CALC: begin
        // bad header spends only the crc-word slot, no payload folded,
        // so done lands where an empty packet would put it
        if (last_i || skip_walk) begin
          state_d = COMPARE_CRC;
        end else begin
          cnt_step_o = 1'b1;
          crc_step_o = 1'b1;
        end
      end
      COMPARE_CRC: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // control state and status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= IDLE;
      class_q  <= ECC_OK;
      done_q   <= 1'b0;
      status_q <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == COMPARE_CRC);
      if (state_q == HEADER_READ) begin
        class_q <= ecc_class_i;
      end
      // status moves together with done and holds until the next packet
      if (state_q == COMPARE_CRC) begin
        status_q.crc_err    <= !skip_walk && (crc_ref_q != crc_i);
        status_q.ecc_corr   <= (class_q == ECC_CORR);
        status_q.ecc_uncorr <= skip_walk;
        status_q.pkt_type   <= hdr_q.pkt_type;
        status_q.byte_cnt   <= hdr_q.byte_cnt;
      end
    end
  end

  // corrected header and stored crc byte
  always_ff @(posedge clk) begin
    if (state_q == HEADER_READ) begin
      hdr_q <= ecc_data_i;
    end
    if (state_q == CRC_CALC && last_i) begin
      crc_ref_q <= rdata_byte_i;
    end
  end

  assign busy_o   = (state_q != IDLE);
  assign done_o   = done_q;
  assign status_o = status_q;

  // done is a strobe, never two in a row
  a_done_pulse: assert property (
    @(posedge clk) disable iff (reset) done_o |=> !done_o
  ) else $error("done held longer than one cycle");

  a_idle_hold: assert property (
    @(posedge clk) disable iff (reset) (state_q == IDLE && !start_i) |=> state_q == IDLE
  ) else $error("left idle without start");

  // header address feeds the counter load and the header read
  a_hdr_addr_stable: assert property (
    @(posedge clk) disable iff (reset) busy_o |-> $stable(addr_hdr_i)
  ) else $error("header address moved during a packet");

endmodule

// File: logic/byte_addr_counter.sv
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module byte_addr_counter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load_i,
  input  logic                      step_i,
  input  pkt_format_pkg::mem_addr_t base_i,
  input  logic [`PKT_CNT_W-1:0]     count_i,
  output pkt_format_pkg::mem_addr_t addr_o,
  output logic                      last_o
);

  import pkt_format_pkg::*;

  localparam int CNT_W = `PKT_CNT_W;

  mem_addr_t        addr_q;
  // payload words still ahead of the crc word
  logic [CNT_W-1:0] left_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q <= '0;
      left_q <= '0;
    end else if (load_i) begin
      // first payload word follows the header
      addr_q <= base_i + mem_addr_t'(1);
      left_q <= count_i;
    end else if (step_i) begin
      addr_q <= addr_q + mem_addr_t'(1);
      left_q <= left_q - CNT_W'(1);
    end
  end

  assign addr_o = addr_q;
  // zero left means addr_o points at the crc word
  assign last_o = (left_q == '0);

  // stepping past the crc word would wrap the count
  a_no_step_at_last: assert property (
    @(posedge clk) disable iff (reset) step_i |-> !last_o
  ) else $error("counter stepped past the crc word");

endmodule

// File: logic/crc8_accum.sv
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module crc8_accum (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear_i,
  input  logic                   step_i,
  input  logic [`PKT_BYTE_W-1:0] byte_i,
  output logic [`PKT_BYTE_W-1:0] crc_o
);

  logic [`PKT_BYTE_W-1:0] crc_q;
  logic [`PKT_BYTE_W-1:0] crc_next;

  // byte enters at the msb end, then eight shift stages
  always_comb begin
    crc_next = crc_q ^ byte_i;
    for (int b = 0; b < 8; b++) begin
      if (crc_next[7]) begin
        crc_next = {crc_next[6:0], 1'b0} ^ `PKT_CRC_POLY;
      end else begin
        crc_next = {crc_next[6:0], 1'b0};
      end
    end
  end

  // clear wins over step
  always_ff @(posedge clk) begin
    if (reset) begin
      crc_q <= '0;
    end else if (clear_i) begin
      crc_q <= '0;
    end else if (step_i) begin
      crc_q <= crc_next;
    end
  end

  assign crc_o = crc_q;

  // sequencer never seeds and folds in the same cycle
  a_clear_step_excl: assert property (
    @(posedge clk) disable iff (reset) !(clear_i && step_i)
  ) else $error("crc clear and step together");

endmodule

// File: logic/hdr_ecc_decoder.sv
`timescale 1ns/1ps

module hdr_ecc_decoder (
  input  pkt_format_pkg::pkt_hdr_t  hdr_i,
  output pkt_format_pkg::hdr_byte_t data_o,
  output pkt_check_pkg::ecc_class_e class_o
);

  import pkt_format_pkg::*;
  import pkt_check_pkg::*;

  // syndrome column of each data bit, d0 on the right
  localparam logic [7:0][3:0] COLS = {
    4'b1100, 4'b1011, 4'b1010, 4'b1001,
    4'b0111, 4'b0110, 4'b0101, 4'b0011
  };

  logic [7:0] rx_data;
  logic [3:0] calc_code;
  logic       calc_par;
  logic       par_err;
  logic [3:0] syndrome;
  logic [7:0] flip;
  hdr_byte_t  fixed;
  ecc_class_e verdict;

  // received data bits, same order as hdr_byte_t
  assign rx_data = {hdr_i.pkt_type, hdr_i.byte_cnt};

  //////////////////////////////////////////////////////////////////////
  // code recompute
  //////////////////////////////////////////////////////////////////////

  assign calc_code[0] = rx_data[0] ^ rx_data[1] ^ rx_data[3] ^ rx_data[4] ^ rx_data[6];
  assign calc_code[1] = rx_data[0] ^ rx_data[2] ^ rx_data[3] ^ rx_data[5] ^ rx_data[6];
  assign calc_code[2] = rx_data[1] ^ rx_data[2] ^ rx_data[3] ^ rx_data[7];
  assign calc_code[3] = rx_data[4] ^ rx_data[5] ^ rx_data[6] ^ rx_data[7];

  // overall parity, tells odd from even error counts
  assign calc_par = ^rx_data;
  assign par_err  = hdr_i.ecc_msb ^ calc_par;

  assign syndrome = hdr_i.ecc_code ^ calc_code;

  //////////////////////////////////////////////////////////////////////
  // classify and correct
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // one-hot of the data bit whose column matches, none for code-bit hits
    flip = '0;
    for (int i = 0; i < 8; i++) begin
      if (syndrome == COLS[i]) begin
        flip[i] = 1'b1;
      end
    end

    if (syndrome == '0) begin
      verdict = ECC_OK;
    end else if (par_err) begin
      verdict = ECC_CORR;
    end else begin
      verdict = ECC_UNCORR;
    end

    // flip on parity error only, an msb-only hit leaves a zero syndrome
    if (par_err) begin
      fixed = hdr_byte_t'(rx_data ^ flip);
    end else begin
      fixed = hdr_byte_t'(rx_data);
    end

    // a clean syndrome must never reach the column table
    if (verdict == ECC_OK) begin
      assert (fixed == hdr_byte_t'(rx_data))
        else $error("ecc decoder altered data on a clean header");
    end
  end

  assign data_o  = fixed;
  assign class_o = verdict;

endmodule

// File: logic/pkt_check_pkg.sv
`include "pkt_check_defs.svh"

package pkt_check_pkg;

  // checker sequencing
  typedef enum logic [1:0] {
    IDLE,
    HEADER_READ,
    CRC_CALC,
    COMPARE_CRC
  } chk_state_e;

  // header ecc verdict
  typedef enum logic [1:0] {
    ECC_OK,
    ECC_CORR,
    ECC_UNCORR
  } ecc_class_e;

  // result reported with done, 11 bits
  typedef struct packed {
    logic                  crc_err;
    logic                  ecc_corr;
    logic                  ecc_uncorr;
    logic [`PKT_CNT_W-1:0] pkt_type;
    logic [`PKT_CNT_W-1:0] byte_cnt;
  } chk_status_t;

endpackage

// File: logic/pkt_format_pkg.sv
`include "pkt_check_defs.svh"

package pkt_format_pkg;

  // word address into the packet memory
  typedef logic [`PKT_ADDR_W-1:0] mem_addr_t;

  // the eight header bits covered by the ecc code
  // pkt_type is the high nibble, byte_cnt the low one
  typedef struct packed {
    logic [`PKT_CNT_W-1:0] pkt_type;
    logic [`PKT_CNT_W-1:0] byte_cnt;
  } hdr_byte_t;

  // header word as it sits at the header address
  typedef struct packed {
    // upper half of the word carries nothing
    logic [15:0]           unused;
    // start-of-packet marker
    logic [2:0]            sop;
    // overall parity over the eight data bits
    logic                  ecc_msb;
    logic [`PKT_CNT_W-1:0] pkt_type;
    // payload length in words, one byte per word
    logic [`PKT_CNT_W-1:0] byte_cnt;
    logic [3:0]            ecc_code;
  } pkt_hdr_t;

endpackage

// File: logic/pkt_check_defs.svh
`ifndef PKT_CHECK_DEFS_SVH
`define PKT_CHECK_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// memory port geometry
//////////////////////////////////////////////////////////////////////

// word address and data widths of the packet memory read port
`define PKT_ADDR_W 14
`define PKT_WORD_W 32
// number of addressable words, upper bound for header placement
`define PKT_MEM_DEPTH (1 << `PKT_ADDR_W)

// payload lane and header nibble widths
`define PKT_BYTE_W 8
`define PKT_CNT_W 4

// crc-8, msb first, zero seed
`define PKT_CRC_POLY 8'h07

`endif
